// ==== rtl/cnn_defines.svh ====
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// Frame geometry in pixels.
`define CNN_IMG_W       28
`define CNN_IMG_H       28

`define CNN_K           5                                   // Kernel side, square kernel.

`define CNN_PIXEL_BW    8                                   // Unsigned input pixel.
`define CNN_WEIGHT_BW   8                                   // Signed kernel weight.
`define CNN_BIAS_BW     16                                  // Signed bias.

// A pixel is zero-extended by one bit before the signed multiply.
`define CNN_PROD_BW     (`CNN_PIXEL_BW + `CNN_WEIGHT_BW + 1)

// Growth for K*K terms keeps the full sum free of overflow.
`define CNN_ACC_BW      (`CNN_PROD_BW + $clog2(`CNN_K * `CNN_K))

`define CNN_OUT_SHIFT   6                                   // Scale down after the bias.
`define CNN_OUT_BW      8                                   // Unsigned output pixel.

`endif

// ==== rtl/cnn_pixel_pkg.sv ====
`include "cnn_defines.svh"

package cnn_pixel_pkg;

    typedef logic [`CNN_PIXEL_BW-1:0] pixel_t;

    // A K x K neighbourhood of the frame, addressed as pix[row][col].
    // Row 0 is the oldest line and column 0 is the leftmost pixel.
    typedef struct packed {
        pixel_t [`CNN_K-1:0][`CNN_K-1:0] pix;
    } window_t;

endpackage

// ==== rtl/cnn_coef_pkg.sv ====
`include "cnn_defines.svh"

package cnn_coef_pkg;

    typedef logic signed [`CNN_WEIGHT_BW-1:0] weight_t;

    // Same layout as the pixel window, addressed as w[row][col].
    typedef struct packed {
        weight_t [`CNN_K-1:0][`CNN_K-1:0] w;
    } kernel_t;

    typedef logic signed [`CNN_BIAS_BW-1:0] bias_t;

    typedef logic signed [`CNN_PROD_BW-1:0] product_t;     // One pixel times one weight.
    typedef logic signed [`CNN_ACC_BW-1:0]  acc_t;         // Sum over the whole window.

    typedef logic [`CNN_OUT_BW-1:0] result_t;

endpackage

// ==== rtl/line_buffer.sv ====
`include "cnn_defines.svh"

module line_buffer #(
    parameter int IMG_W = `CNN_IMG_W,
    parameter int IMG_H = `CNN_IMG_H
) (
    input  logic                   clk,
    input  logic                   reset_n,

    input  logic                   i_in_valid,
    input  cnn_pixel_pkg::pixel_t  i_pixel,

    output logic                   o_window_valid,
    output cnn_pixel_pkg::window_t o_window
);
    import cnn_pixel_pkg::*;

    localparam int K  = `CNN_K;
    localparam int XW = $clog2(IMG_W);
    localparam int YW = $clog2(IMG_H);

    logic [XW-1:0] x_cnt;
    logic [YW-1:0] y_cnt;
    logic          last_col;
    logic          last_row;
    logic          win_pos;

    pixel_t  line_mem [K-1][IMG_W];                        // Row 0 holds the oldest line.
    pixel_t  column   [K];
    window_t win_q;

    assign last_col = (x_cnt == XW'(IMG_W - 1));
    assign last_row = (y_cnt == YW'(IMG_H - 1));

    // The window is complete once K columns and K rows have been seen.
    assign win_pos  = (x_cnt >= XW'(K - 1)) && (y_cnt >= YW'(K - 1));

    // Raster position of the next pixel, wrapping at the end of the frame.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (i_in_valid) begin
            if (last_col) begin
                x_cnt <= '0;
                if (last_row) begin
                    y_cnt <= '0;                           // Next frame starts at the top.
                end else begin
                    y_cnt <= y_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    // Vertical slice under the current column, newest pixel at the bottom.
    always_comb begin
        for (int r = 0; r < K - 1; r++) begin
            column[r] = line_mem[r][x_cnt];
        end
        column[K-1] = i_pixel;
    end

    // Each column of the storage moves up by one line as the new pixel arrives.
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int r = 0; r < K - 2; r++) begin
                line_mem[r][x_cnt] <= line_mem[r + 1][x_cnt];
            end
            line_mem[K-2][x_cnt] <= i_pixel;
        end
    end

    // K-wide shift register of columns. After the pixel at column x it holds columns x-4 to x.
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    win_q.pix[r][c] <= win_q.pix[r][c + 1];
                end
                win_q.pix[r][K-1] <= column[r];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_window_valid <= 1'b0;
        end else begin
            o_window_valid <= i_in_valid && win_pos;       // Windows wrapping a line edge are dropped.
        end
    end

    assign o_window = win_q;

endmodule

// ==== rtl/conv_mac.sv ====
`include "cnn_defines.svh"

module conv_mac (
    input  logic                   clk,
    input  logic                   reset_n,

    input  logic                   i_window_valid,
    input  cnn_pixel_pkg::window_t i_window,
    input  cnn_coef_pkg::kernel_t  i_kernel,

    output logic                   o_acc_valid,
    output cnn_coef_pkg::acc_t     o_acc
);
    import cnn_coef_pkg::*;

    localparam int K = `CNN_K;

    product_t prod_d  [K][K];
    product_t prod_q  [K][K];
    acc_t     row_sum [K];
    acc_t     acc_d;
    logic     prod_valid;

    // Pixels are unsigned, so a zero bit on top keeps them positive in the signed multiply.
    always_comb begin
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                prod_d[r][c] = $signed({1'b0, i_window.pix[r][c]}) * $signed(i_kernel.w[r][c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_window_valid) begin
            prod_q <= prod_d;
        end
    end

    // Row sums first, then the rows, all at accumulator width.
    always_comb begin
        acc_d = '0;
        for (int r = 0; r < K; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < K; c++) begin
                row_sum[r] = row_sum[r] + acc_t'(prod_q[r][c]);
            end
            acc_d = acc_d + row_sum[r];
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            o_acc <= acc_d;
        end
    end

    // Strobe follows the data through both register stages.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_valid  <= 1'b0;
            o_acc_valid <= 1'b0;
        end else begin
            prod_valid  <= i_window_valid;
            o_acc_valid <= prod_valid;
        end
    end

endmodule

// ==== rtl/bias_relu.sv ====
`include "cnn_defines.svh"

module bias_relu (
    input  logic                  clk,
    input  logic                  reset_n,

    input  logic                  i_acc_valid,
    input  cnn_coef_pkg::acc_t    i_acc,
    input  cnn_coef_pkg::bias_t   i_bias,

    output logic                  o_out_valid,
    output cnn_coef_pkg::result_t o_out_pixel
);
    import cnn_coef_pkg::*;

    localparam int SUM_BW = $bits(acc_t) + 1;

    logic signed [SUM_BW-1:0] sum;
    logic signed [SUM_BW-1:0] relu;
    logic signed [SUM_BW-1:0] shifted;
    result_t                  out_d;

    always_comb begin
        sum     = i_acc + i_bias;                          // Both sides sign-extend to SUM_BW.
        relu    = sum[SUM_BW-1] ? '0 : sum;
        shifted = relu >>> `CNN_OUT_SHIFT;
        // Any bit above the output width means the value is out of range.
        out_d   = (|shifted[SUM_BW-1:`CNN_OUT_BW]) ? '1 : shifted[`CNN_OUT_BW-1:0];
    end

    always_ff @(posedge clk) begin
        if (i_acc_valid) begin
            o_out_pixel <= out_d;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= i_acc_valid;
        end
    end

endmodule

// ==== rtl/conv_layer_top.sv ====
module conv_layer_top (
    input  logic                  clk,
    input  logic                  reset_n,

    input  logic                  i_in_valid,
    input  cnn_pixel_pkg::pixel_t i_pixel,
    input  cnn_coef_pkg::kernel_t i_kernel,
    input  cnn_coef_pkg::bias_t   i_bias,

    output logic                  o_out_valid,
    output cnn_coef_pkg::result_t o_out_pixel
);
    import cnn_pixel_pkg::*;
    import cnn_coef_pkg::*;

    logic    window_valid;
    window_t window;
    logic    acc_valid;
    acc_t    acc;

    line_buffer u_line_buffer (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_in_valid     (i_in_valid),
        .i_pixel        (i_pixel),
        .o_window_valid (window_valid),
        .o_window       (window)
    );

    conv_mac u_conv_mac (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_window_valid (window_valid),
        .i_window       (window),
        .i_kernel       (i_kernel),
        .o_acc_valid    (acc_valid),
        .o_acc          (acc)
    );

    bias_relu u_bias_relu (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_acc_valid    (acc_valid),
        .i_acc          (acc),
        .i_bias         (i_bias),
        .o_out_valid    (o_out_valid),
        .o_out_pixel    (o_out_pixel)
    );

endmodule

// ==== testbench/tb_conv_layer.sv ====
`include "cnn_defines.svh"

module tb_conv_layer;
    timeunit 1ns;
    timeprecision 1ps;

    import cnn_pixel_pkg::*;
    import cnn_coef_pkg::*;

    parameter int SEED = 75318;

    localparam int W         = `CNN_IMG_W;
    localparam int H         = `CNN_IMG_H;
    localparam int K         = `CNN_K;
    localparam int OUTS      = (W - K + 1) * (H - K + 1);  // Results per frame.
    localparam int OUT_MAX   = (1 << `CNN_OUT_BW) - 1;
    localparam int LATENCY   = 4;
    localparam int MAX_GAP   = 3;
    localparam int PERIOD_NS = 40;
    // Five frames at full rate, two frames with up to MAX_GAP idle cycles per pixel.
    localparam int RUN_CYCLES = (5 + 2 * (MAX_GAP + 1)) * W * H + 2000;

    logic    clk = 1'b0;
    logic    reset_n;
    logic    in_valid;
    pixel_t  pixel;
    kernel_t kernel;
    bias_t   bias;
    logic    out_valid;
    result_t out_pixel;

    integer  seed;
    int      cycle = 0;
    int      errors;
    int      err_mark;
    int      out_count;
    int      tests_passed;
    int      tests_failed;

    int      kw [K][K];
    int      bias_val;
    int      frame [2][H][W];                              // Two slots for back-to-back frames.
    int      exp_q [$];
    int      stamp_q [$];

    conv_layer_top dut0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (in_valid),
        .i_pixel     (pixel),
        .i_kernel    (kernel),
        .i_bias      (bias),
        .o_out_valid (out_valid),
        .o_out_pixel (out_pixel)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected 0x%0h actual 0x%0h at cycle %0d",
                     name, expected, actual, cycle);
            errors++;
        end
    endtask

    // Outputs only change on the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (reset_n && out_valid) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("Output 0x%0h arrived at cycle %0d with no result expected",
                         out_pixel, cycle);
                errors++;
            end else begin
                check_value("o_out_pixel", exp_q.pop_front(), out_pixel);
            end
            if (stamp_q.size() != 0) begin
                check_value("o_out_valid latency", LATENCY, cycle - stamp_q.pop_front());
            end
        end
    end

    task automatic apply_coefs();
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                kernel.w[r][c] = weight_t'(kw[r][c]);
            end
        end
        bias = bias_t'(bias_val);
    endtask

    // Weights fall in [-span, span-1].
    task automatic random_coefs(input int span);
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                kw[r][c] = (($random(seed) & 32'h7fff_ffff) % (2 * span)) - span;
            end
        end
        bias_val = (($random(seed) & 32'h7fff_ffff) % 8192) - 4096;
        apply_coefs();
    endtask

    task automatic uniform_coefs(input int weight, input int b);
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                kw[r][c] = weight;
            end
        end
        bias_val = b;
        apply_coefs();
    endtask

    task automatic fill_frame(input int slot, input int lo, input int hi);
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                frame[slot][y][x] = lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
            end
        end
    endtask

    // Valid convolution in raster order, then bias, ReLU, shift and saturation.
    task automatic push_expected(input int slot);
        int acc;
        int val;
        for (int oy = 0; oy <= H - K; oy++) begin
            for (int ox = 0; ox <= W - K; ox++) begin
                acc = 0;
                for (int r = 0; r < K; r++) begin
                    for (int c = 0; c < K; c++) begin
                        acc += frame[slot][oy + r][ox + c] * kw[r][c];
                    end
                end
                val = acc + bias_val;
                if (val < 0) begin
                    val = 0;
                end
                val = val >>> `CNN_OUT_SHIFT;
                if (val > OUT_MAX) begin
                    val = OUT_MAX;
                end
                exp_q.push_back(val);
            end
        end
    endtask

    task automatic drive_pixel(input int value, input bit completes);
        @(negedge clk);
        in_valid = 1'b1;
        pixel    = pixel_t'(value);
        if (completes) begin
            stamp_q.push_back(cycle);                      // Pixel is taken by the next edge.
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        pixel    = pixel_t'($random(seed));                // Junk on the bus while idle.
    endtask

    task automatic send_frame(input int slot, input bit gaps);
        int n_idle;
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                if (gaps) begin
                    n_idle = (($random(seed) & 7) < 3) ? ($random(seed) & MAX_GAP) : 0;
                    repeat (n_idle) idle_cycle();
                end
                drive_pixel(frame[slot][y][x], (x >= K - 1) && (y >= K - 1));
            end
        end
    endtask

    // Waits for the expected queue to empty, then leaves room for stray outputs.
    task automatic drain();
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_q.size() != 0 && waited < LATENCY + 20) begin
            idle_cycle();
            waited++;
        end
        repeat (8) idle_cycle();
        if (exp_q.size() != 0) begin
            $display("%0d expected outputs never appeared", exp_q.size());
            errors++;
            exp_q.delete();
        end
        stamp_q.delete();
    endtask

    task automatic begin_test();
        err_mark  = errors;
        out_count = 0;
    endtask

    task automatic end_test(input int num, input string name, input int exp_count);
        check_value("output count", exp_count, out_count);
        if (errors == err_mark) begin
            $display("Test %0d (%s) passed with %0d outputs", num, name, out_count);
            tests_passed++;
        end else begin
            $display("Test %0d (%s) failed with %0d errors", num, name, errors - err_mark);
            tests_failed++;
        end
    endtask

    initial begin
        #(RUN_CYCLES * PERIOD_NS);
        $display("Watchdog expired after %0d cycles before the tests finished", RUN_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed         = SEED;
        errors       = 0;
        err_mark     = 0;
        out_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        reset_n      = 1'b0;
        in_valid     = 1'b0;
        pixel        = '0;
        kernel       = '0;
        bias         = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        begin_test();
        repeat (40) begin
            idle_cycle();
            check_value("o_out_valid", 0, out_valid);
        end
        end_test(1, "idle after reset", 0);

        begin_test();
        random_coefs(16);
        fill_frame(0, 0, 255);
        push_expected(0);
        send_frame(0, 1'b0);
        drain();
        end_test(2, "continuous frame", OUTS);

        begin_test();
        random_coefs(16);
        fill_frame(0, 0, 255);
        push_expected(0);
        send_frame(0, 1'b1);
        drain();
        end_test(3, "frame with gaps", OUTS);

        begin_test();
        uniform_coefs(127, 0);                             // Bright pixels push past the top.
        fill_frame(0, 192, 255);
        push_expected(0);
        send_frame(0, 1'b0);
        drain();
        uniform_coefs(-128, 1000);                         // Bias too small to lift the sum.
        fill_frame(0, 1, 255);
        push_expected(0);
        send_frame(0, 1'b0);
        drain();
        end_test(4, "extreme kernels", 2 * OUTS);

        begin_test();
        random_coefs(64);
        fill_frame(0, 0, 255);
        fill_frame(1, 0, 127);
        push_expected(0);
        push_expected(1);
        send_frame(0, 1'b0);
        send_frame(1, 1'b0);
        drain();
        end_test(5, "back-to-back frames", 2 * OUTS);

        begin_test();
        random_coefs(32);
        fill_frame(0, 0, 255);
        push_expected(0);
        send_frame(0, 1'b1);
        drain();
        end_test(6, "output latency", OUTS);

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/cnn_pixel_pkg.sv
rtl/cnn_coef_pkg.sv
rtl/line_buffer.sv
rtl/conv_mac.sv
rtl/bias_relu.sv
rtl/conv_layer_top.sv
testbench/tb_conv_layer.sv

// ==== Makefile ====
# Verilator flow for the convolution layer.
# Override from the command line, for example: make sim SEED=1234 LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_conv_layer
RTL_TOP   ?= conv_layer_top
SEED      ?= 75318
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "RESULT: PASS" $(LOG); then \
		echo "Simulation passed, log in $(LOG)"; \
	else \
		echo "Simulation failed, log in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
